/* include/drt_map.svh */
// Device table address map
`ifndef DRT_MAP_SVH
`define DRT_MAP_SVH

// region select field of a word address
// top byte picks the slave
`define DRT_REGION_OF(a) a[drt_pkg::SEL_MSB:drt_pkg::SEL_LSB]

// word index inside a region
// select field cleared, low bits kept as they are
`define DRT_INDEX_OF(a) ((a) & {{(drt_pkg::ADDR_W - drt_pkg::SEL_LSB){1'b0}}, \
	{drt_pkg::SEL_LSB{1'b1}}})

// both take a plain word address
// the decoder forwards only the index to its slaves
// the host still sees the full address

`endif

/* design/drt_pkg.sv */
// Device table shared definitions
`default_nettype none

package drt_pkg;

	// bus widths, word addressed
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;

	// table layout
	localparam int DRT_HEADER_WORDS = 4;
	localparam int DRT_DEV_WORDS = 4;
	localparam int DRT_NUM_DEVICES = 1;
	localparam int DRT_SIZE = DRT_HEADER_WORDS + DRT_NUM_DEVICES * DRT_DEV_WORDS;

	// rom contents, one hex word per line
	localparam string DRT_INIT_FILE = "drt_rom.hex";

	// region select bits of the address
	localparam int SEL_MSB = 31;
	localparam int SEL_LSB = 24;
	localparam logic [SEL_MSB-SEL_LSB:0] REGION_DRT = 8'h00;
	localparam logic [SEL_MSB-SEL_LSB:0] REGION_SCRATCH = 8'h01;

	// scratch block
	localparam int SCRATCH_REGS = 4;
	localparam int DOORBELL_IDX = 3;

	// answer for addresses nobody owns
	localparam logic [DATA_W-1:0] UNMAPPED_DATA = 32'hDEAD_BEEF;

	// decoded target of a bus cycle
	typedef enum logic [1:0] {drt, scratch, none} drt_region_t;

endpackage

`default_nettype wire

/* design/wb_bus_if.sv */
// Wishbone bus interface
`timescale 1ns/1ps
`default_nettype none

interface wb_bus_if;
	import drt_pkg::*;

	// cycle control
	logic cyc;
	logic stb;
	logic we;
	logic [ADDR_W-1:0] adr;
	// data both ways
	logic [DATA_W-1:0] dat_m2s;
	logic [DATA_W-1:0] dat_s2m;
	// slave response
	logic ack;
	logic irq;

	// master side drives the request
	modport master (output cyc, stb, we, adr, dat_m2s, input dat_s2m, ack, irq);

	// slave side answers
	modport slave (input cyc, stb, we, adr, dat_m2s, output dat_s2m, ack, irq);

endinterface

`default_nettype wire

/* design/device_rom_table.sv */
// Device ROM table slave
`timescale 1ns/1ps
`default_nettype none

module device_rom_table (
	input logic clk,
	input logic rst,
	wb_bus_if.slave bus
);
	import drt_pkg::*;

	// header words then one entry per device
	logic [DATA_W-1:0] rom [DRT_SIZE];
	logic [DATA_W-1:0] rd_word;
	logic in_range;

	initial begin
		$readmemh(DRT_INIT_FILE, rom);
	end

	// anything past the table reads as zero
	assign in_range = (bus.adr < DRT_SIZE);
	assign rd_word = in_range ? rom[bus.adr[$clog2(DRT_SIZE)-1:0]] : '0;

	// table never interrupts
	assign bus.irq = 1'b0;

	// ack handshake
	// raise on cyc and stb, hold while stb stays up
	always_ff @(posedge clk) begin
		if (rst) begin
			bus.ack <= 1'b0;
		end else if (bus.cyc && bus.stb) begin
			bus.ack <= 1'b1;
		end else if (bus.ack && !bus.stb) begin
			// master let go of stb
			bus.ack <= 1'b0;
		end
	end

	// read data
	// writes are acked but change nothing, they return zero
	always_ff @(posedge clk) begin
		if (bus.cyc && bus.stb) begin
			if (bus.we) begin
				bus.dat_s2m <= '0;
			end else begin
				bus.dat_s2m <= rd_word;
			end
		end
	end

endmodule

`default_nettype wire

/* design/wb_scratch_regs.sv */
// Scratch register block
`timescale 1ns/1ps
`default_nettype none

module wb_scratch_regs (
	input logic clk,
	input logic rst,
	wb_bus_if.slave bus
);
	import drt_pkg::*;

	// four general registers, the last one is the doorbell
	logic [DATA_W-1:0] regs [SCRATCH_REGS];
	logic [$clog2(SCRATCH_REGS)-1:0] idx;
	logic access;
	logic wr;

	// low address bits pick the register
	assign idx = bus.adr[$clog2(SCRATCH_REGS)-1:0];
	assign access = bus.cyc && bus.stb;
	assign wr = access && bus.we;

	// ack handshake
	always_ff @(posedge clk) begin
		if (rst) begin
			bus.ack <= 1'b0;
		end else if (access) begin
			bus.ack <= 1'b1;
		end else if (bus.ack && !bus.stb) begin
			bus.ack <= 1'b0;
		end
	end

	// register file and doorbell interrupt
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < SCRATCH_REGS; i++) begin
				regs[i] <= '0;
			end
			bus.irq <= 1'b0;
		end else if (wr) begin
			regs[idx] <= bus.dat_m2s;
			// irq follows the doorbell value being written
			// so it is up by the time the ack lands
			if (idx == DOORBELL_IDX) begin
				bus.irq <= |bus.dat_m2s;
			end
		end
	end

	// response data
	// a write echoes the stored value
	always_ff @(posedge clk) begin
		if (access) begin
			if (bus.we) begin
				bus.dat_s2m <= bus.dat_m2s;
			end else begin
				bus.dat_s2m <= regs[idx];
			end
		end
	end

	// other registers never touch irq
	// the write repeats while stb is held, same value

endmodule

`default_nettype wire

/* design/wb_addr_decoder.sv */
// Wishbone address decoder
`timescale 1ns/1ps
`default_nettype none

`include "drt_map.svh"

module wb_addr_decoder (
	input logic clk,
	input logic rst,
	wb_bus_if.slave m,
	wb_bus_if.master s_drt,
	wb_bus_if.master s_scr
);
	import drt_pkg::*;

	drt_region_t region;
	// ack for cycles that hit no slave
	logic none_ack;

	// region from the top address byte
	always_comb begin
		case (`DRT_REGION_OF(m.adr))
			REGION_DRT: region = drt;
			REGION_SCRATCH: region = scratch;
			default: region = none;
		endcase
	end

	// only the selected slave sees cyc and stb
	assign s_drt.cyc = m.cyc && (region == drt);
	assign s_drt.stb = m.stb && (region == drt);
	assign s_drt.we = m.we;
	assign s_drt.adr = `DRT_INDEX_OF(m.adr);
	assign s_drt.dat_m2s = m.dat_m2s;

	assign s_scr.cyc = m.cyc && (region == scratch);
	assign s_scr.stb = m.stb && (region == scratch);
	assign s_scr.we = m.we;
	assign s_scr.adr = `DRT_INDEX_OF(m.adr);
	assign s_scr.dat_m2s = m.dat_m2s;

	// unmapped space answers like a slave would
	always_ff @(posedge clk) begin
		if (rst) begin
			none_ack <= 1'b0;
		end else if (m.cyc && m.stb && (region == none)) begin
			none_ack <= 1'b1;
		end else if (none_ack && !m.stb) begin
			none_ack <= 1'b0;
		end
	end

	// response mux
	always_comb begin
		case (region)
			drt: begin
				m.dat_s2m = s_drt.dat_s2m;
				m.ack = s_drt.ack;
			end
			scratch: begin
				m.dat_s2m = s_scr.dat_s2m;
				m.ack = s_scr.ack;
			end
			default: begin
				m.dat_s2m = UNMAPPED_DATA;
				m.ack = none_ack;
			end
		endcase
	end

	// doorbell interrupt from the scratch block
	assign m.irq = s_scr.irq;

endmodule

`default_nettype wire

/* design/wb_host_master.sv */
// Host request bus master
`timescale 1ns/1ps
`default_nettype none

module wb_host_master (
	input logic clk,
	input logic rst,
	input logic req_i,
	input logic we_i,
	input logic [drt_pkg::ADDR_W-1:0] adr_i,
	input logic [drt_pkg::DATA_W-1:0] wdata_i,
	output logic busy_o,
	output logic done_o,
	output logic [drt_pkg::DATA_W-1:0] rdata_o,
	wb_bus_if.master bus
);
	import drt_pkg::*;

	typedef enum logic [1:0] {idle, wait_ack, wait_release} state_t;

	state_t state;
	logic take;

	// new request only accepted when idle
	assign take = (state == idle) && req_i;

	// busy from request edge until the slave drops ack
	assign busy_o = (state != idle);

	// controller
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			bus.cyc <= 1'b0;
			bus.stb <= 1'b0;
			done_o <= 1'b0;
			rdata_o <= '0;
		end else begin
			// done is a single cycle pulse
			done_o <= 1'b0;
			case (state)
				idle: begin
					if (req_i) begin
						bus.cyc <= 1'b1;
						bus.stb <= 1'b1;
						state <= wait_ack;
					end
				end
				wait_ack: begin
					// grab the data, end the cycle
					if (bus.ack) begin
						rdata_o <= bus.dat_s2m;
						done_o <= 1'b1;
						bus.cyc <= 1'b0;
						bus.stb <= 1'b0;
						state <= wait_release;
					end
				end
				wait_release: begin
					// slave clears ack one cycle after stb falls
					if (!bus.ack) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// request fields held for the whole cycle
	always_ff @(posedge clk) begin
		if (take) begin
			bus.we <= we_i;
			bus.adr <= adr_i;
			bus.dat_m2s <= wdata_i;
		end
	end

endmodule

`default_nettype wire

/* design/drt_subsystem_top.sv */
// Device table subsystem top
`timescale 1ns/1ps
`default_nettype none

module drt_subsystem_top (
	input logic clk,
	input logic rst,
	input logic req_i,
	input logic we_i,
	input logic [drt_pkg::ADDR_W-1:0] adr_i,
	input logic [drt_pkg::DATA_W-1:0] wdata_i,
	output logic busy_o,
	output logic done_o,
	output logic [drt_pkg::DATA_W-1:0] rdata_o,
	output logic irq_o
);

	// master to decoder
	wb_bus_if m_bus ();
	// decoder to each slave
	wb_bus_if s_drt ();
	wb_bus_if s_scr ();

	wb_host_master i_host_master (
		.clk(clk),
		.rst(rst),
		.req_i(req_i),
		.we_i(we_i),
		.adr_i(adr_i),
		.wdata_i(wdata_i),
		.busy_o(busy_o),
		.done_o(done_o),
		.rdata_o(rdata_o),
		.bus(m_bus)
	);

	wb_addr_decoder i_addr_decoder (.clk(clk), .rst(rst), .m(m_bus), .s_drt(s_drt), .s_scr(s_scr));

	// region 0x00
	device_rom_table i_drt (.clk(clk), .rst(rst), .bus(s_drt));

	// region 0x01
	wb_scratch_regs i_scratch (.clk(clk), .rst(rst), .bus(s_scr));

	// doorbell interrupt out to the host
	assign irq_o = m_bus.irq;

endmodule

`default_nettype wire

/* bench/drt_subsystem_sva.sv */
// Bus protocol assertions
`timescale 1ns/1ps
`default_nettype none

module drt_subsystem_sva (
	input logic clk,
	input logic rst,
	input logic busy_i,
	input logic done_i,
	input logic cyc_i,
	input logic stb_i,
	input logic ack_i,
	input logic [drt_pkg::ADDR_W-1:0] adr_i
);

	// done pulse only inside a busy window
	done_in_busy: assert property (@(posedge clk) disable iff (rst) done_i |-> busy_i)
		else $error("done_o high while busy_o is low");

	// no strobe outside a bus cycle
	stb_in_cyc: assert property (@(posedge clk) disable iff (rst) stb_i |-> cyc_i)
		else $error("stb high without cyc");

	// address held until the slave answers
	adr_held: assert property (@(posedge clk) disable iff (rst)
		stb_i && !ack_i |=> $stable(adr_i))
		else $error("adr changed while waiting for ack");

	// slave releases ack one cycle after strobe drops
	ack_release: assert property (@(posedge clk) disable iff (rst)
		$fell(stb_i) |=> $fell(ack_i))
		else $error("ack did not fall one cycle after stb fell");

endmodule

// master side of the decoder, after the response mux
bind drt_subsystem_top drt_subsystem_sva i_sva (
	.clk(clk),
	.rst(rst),
	.busy_i(busy_o),
	.done_i(done_o),
	.cyc_i(m_bus.cyc),
	.stb_i(m_bus.stb),
	.ack_i(m_bus.ack),
	.adr_i(m_bus.adr)
);

`default_nettype wire

/* bench/tb_drt_subsystem.sv */
// Device table subsystem testbench
`timescale 1ns/1ps
`default_nettype none

`include "drt_map.svh"

module tb_drt_subsystem;
	import drt_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	// fixed request latency, req_i edge to busy_o low
	localparam int REQ_CYCLES = 5;
	// upper bound on requests issued below
	localparam int MAX_REQUESTS = 100;
	localparam int MARGIN_CYCLES = 200;
	localparam int WATCHDOG_NS =
		(MAX_REQUESTS * REQ_CYCLES + MARGIN_CYCLES + RESET_CYCLES) * CLK_PERIOD;
	// reads run past the table end
	localparam int TABLE_SPAN = 16;
	localparam logic [15:0] HDR_ID = 16'h0001;
	localparam logic [15:0] HDR_VERSION = 16'h0001;

	logic clk;
	logic rst;
	logic req_i;
	logic we_i;
	logic [ADDR_W-1:0] adr_i;
	logic [DATA_W-1:0] wdata_i;
	logic busy_o;
	logic done_o;
	logic [DATA_W-1:0] rdata_o;
	logic irq_o;

	// model state
	logic [DATA_W-1:0] drt_model [DRT_SIZE];
	logic [DATA_W-1:0] scratch_shadow [SCRATCH_REGS];
	// requests still waiting for their done_o
	logic pend_we [$];
	logic [ADDR_W-1:0] pend_adr [$];
	logic [DATA_W-1:0] pend_wdata [$];

	int seed;
	int errors;
	int checks;
	int done_count;
	int req_count;

	drt_subsystem_top i_dut (
		.clk(clk),
		.rst(rst),
		.req_i(req_i),
		.we_i(we_i),
		.adr_i(adr_i),
		.wdata_i(wdata_i),
		.busy_o(busy_o),
		.done_o(done_o),
		.rdata_o(rdata_o),
		.irq_o(irq_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2);
			clk = ~clk;
		end
	end

	// word address from region code and in-region index
	function automatic logic [ADDR_W-1:0] region_addr(input logic [7:0] region, input int index);
		return {region, index[23:0]};
	endfunction

	// expected rdata from the address map rules
	function automatic logic [DATA_W-1:0] expected_rdata(input logic we,
		input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] wdata);
		drt_region_t region;
		logic [ADDR_W-1:0] idx;
		logic [DATA_W-1:0] result;
		case (`DRT_REGION_OF(adr))
			REGION_DRT: region = drt;
			REGION_SCRATCH: region = scratch;
			default: region = none;
		endcase
		idx = `DRT_INDEX_OF(adr);
		result = UNMAPPED_DATA;
		if (region == drt) begin
			// table writes are dropped and answer zero
			if (we || idx >= DRT_SIZE) begin
				result = '0;
			end else begin
				result = drt_model[idx[$clog2(DRT_SIZE)-1:0]];
			end
		end else if (region == scratch) begin
			// write echoes the new value
			if (we) begin
				result = wdata;
			end else begin
				result = scratch_shadow[idx[$clog2(SCRATCH_REGS)-1:0]];
			end
		end
		return result;
	endfunction

	task automatic update_shadow(input logic we, input logic [ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] wdata);
		if (we && (`DRT_REGION_OF(adr) == REGION_SCRATCH)) begin
			scratch_shadow[adr[$clog2(SCRATCH_REGS)-1:0]] = wdata;
		end
	endtask

	// every done_o against the model
	always @(negedge clk) begin : check_done
		logic we;
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] wdata;
		logic [DATA_W-1:0] exp;
		logic exp_irq;
		if (!rst && done_o) begin
			done_count++;
			if (pend_we.size() == 0) begin
				$display("done_o at %0t with no request pending", $time);
				errors++;
			end else begin
				we = pend_we.pop_front();
				adr = pend_adr.pop_front();
				wdata = pend_wdata.pop_front();
				exp = expected_rdata(we, adr, wdata);
				update_shadow(we, adr, wdata);
				// irq follows the doorbell as it stands after this write
				exp_irq = (scratch_shadow[DOORBELL_IDX] != '0);
				checks++;
				assert (rdata_o === exp) else begin
					$display("FAIL %0t: %s adr %h rdata %h expected %h", $time,
						we ? "write" : "read", adr, rdata_o, exp);
					errors++;
				end
				assert (irq_o === exp_irq) else begin
					$display("FAIL %0t: adr %h irq %b expected %b", $time, adr, irq_o, exp_irq);
					errors++;
				end
			end
		end
	end

	// one request, back once busy_o drops
	task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
		@(posedge clk);
		#2;
		pend_we.push_back(we);
		pend_adr.push_back(adr);
		pend_wdata.push_back(wdata);
		req_i = 1'b1;
		we_i = we;
		adr_i = adr;
		wdata_i = wdata;
		req_count++;
		@(posedge clk);
		#2;
		req_i = 1'b0;
		// a hang here is caught by the watchdog
		while (!done_o) @(negedge clk);
		rdata = rdata_o;
		while (busy_o) @(negedge clk);
	endtask

	task automatic read_word(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] rdata);
		bus_access(1'b0, adr, '0, rdata);
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] wdata);
		logic [DATA_W-1:0] rdata;
		bus_access(1'b1, adr, wdata, rdata);
	endtask

	// second pulse lands in the busy window
	task automatic request_while_busy(input logic [ADDR_W-1:0] adr);
		@(posedge clk);
		#2;
		pend_we.push_back(1'b0);
		pend_adr.push_back(adr);
		pend_wdata.push_back('0);
		req_i = 1'b1;
		we_i = 1'b0;
		adr_i = adr;
		wdata_i = '0;
		req_count++;
		@(posedge clk);
		#2;
		req_i = 1'b0;
		@(posedge clk);
		#2;
		assert (busy_o) else begin
			$display("FAIL %0t: busy_o low during a request", $time);
			errors++;
		end
		// a write to scratch 0 that must be dropped
		req_i = 1'b1;
		we_i = 1'b1;
		adr_i = region_addr(REGION_SCRATCH, 0);
		wdata_i = 32'h1234_5678;
		@(posedge clk);
		#2;
		req_i = 1'b0;
		while (!done_o) @(negedge clk);
		while (busy_o) @(negedge clk);
		// room for a stray done_o
		repeat (8) @(negedge clk);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run still going after %0d ns", WATCHDOG_NS);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		logic [DATA_W-1:0] rd;
		logic [DATA_W-1:0] wd;
		int idx;
		seed = 14;
		errors = 0;
		checks = 0;
		done_count = 0;
		req_count = 0;
		req_i = 1'b0;
		we_i = 1'b0;
		adr_i = '0;
		wdata_i = '0;
		rst = 1'b1;
		$readmemh(DRT_INIT_FILE, drt_model);
		for (int i = 0; i < SCRATCH_REGS; i++) begin
			scratch_shadow[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;

		// outputs idle after reset
		@(negedge clk);
		assert (busy_o === 1'b0 && done_o === 1'b0 && irq_o === 1'b0 && rdata_o === '0)
		else begin
			$display("FAIL %0t: outputs not idle after reset", $time);
			errors++;
		end

		// whole table, then the empty space past it
		for (int i = 0; i < TABLE_SPAN; i++) begin
			read_word(region_addr(REGION_DRT, i), rd);
		end
		read_word(region_addr(REGION_DRT, 0), rd);
		assert (rd[31:16] == HDR_ID && rd[15:0] == HDR_VERSION) else begin
			$display("FAIL %0t: header id %h version %h", $time, rd[31:16], rd[15:0]);
			errors++;
		end

		// table is read only
		for (int i = 0; i < DRT_SIZE; i++) begin
			wd = $random(seed);
			write_word(region_addr(REGION_DRT, i), wd);
		end
		for (int i = 0; i < DRT_SIZE; i++) begin
			read_word(region_addr(REGION_DRT, i), rd);
		end

		// scratch, mixed reads and writes
		for (int n = 0; n < 24; n++) begin
			idx = $random(seed) & 3;
			if (($random(seed) & 1) != 0) begin
				wd = $random(seed);
				write_word(region_addr(REGION_SCRATCH, idx), wd);
			end else begin
				read_word(region_addr(REGION_SCRATCH, idx), rd);
			end
		end
		for (int i = 0; i < SCRATCH_REGS; i++) begin
			read_word(region_addr(REGION_SCRATCH, i), rd);
		end

		// doorbell on and off, other registers leave irq alone
		write_word(region_addr(REGION_SCRATCH, DOORBELL_IDX), '0);
		for (int i = 0; i < DOORBELL_IDX; i++) begin
			write_word(region_addr(REGION_SCRATCH, i), 32'hFFFF_0000 | i);
		end
		write_word(region_addr(REGION_SCRATCH, DOORBELL_IDX), 32'h0000_00A5);
		for (int i = 0; i < DOORBELL_IDX; i++) begin
			write_word(region_addr(REGION_SCRATCH, i), '0);
		end
		write_word(region_addr(REGION_SCRATCH, DOORBELL_IDX), '0);
		wd = $random(seed) | 1;
		write_word(region_addr(REGION_SCRATCH, DOORBELL_IDX), wd);
		write_word(region_addr(REGION_SCRATCH, DOORBELL_IDX), '0);

		// nobody owns these
		read_word(region_addr(8'h02, 0), rd);
		read_word(region_addr(8'h02, 5), rd);
		write_word(region_addr(8'h02, 1), 32'h5555_AAAA);
		read_word(region_addr(8'hFF, 32'h12_3456), rd);
		write_word(region_addr(8'hFF, 0), 32'h0F0F_0F0F);

		// ignored pulse, then scratch 0 must be untouched
		request_while_busy(region_addr(REGION_DRT, 1));
		read_word(region_addr(REGION_SCRATCH, 0), rd);

		repeat (4) @(negedge clk);
		assert (done_count == req_count && pend_we.size() == 0) else begin
			$display("FAIL %0t: %0d done_o pulses for %0d requests", $time, done_count,
				req_count);
			errors++;
		end
		$display("requests %0d, checks %0d, errors %0d", req_count, checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
design/drt_pkg.sv
design/wb_bus_if.sv
design/device_rom_table.sv
design/wb_scratch_regs.sv
design/wb_addr_decoder.sv
design/wb_host_master.sv
design/drt_subsystem_top.sv
bench/drt_subsystem_sva.sv
bench/tb_drt_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_drt_subsystem
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator output directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* drt_rom.hex */
// one 32-bit word per line: header id/version, device count, two reserved,
// then device id, info, memory offset, size
00010001
00000001
00000000
00000000
00000002
00000000
01000000
00000004
